//--- sim.f
+incdir+include
design/core_pkg.sv
design/cmd_decode.sv
design/setting_bank.sv
design/readback_mux.sv
design/radio_io_path.sv
design/core_ctrl_top.sv
bench/tb_core_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the core control testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
   --top-module tb_core_ctrl -o tb_core_ctrl > sim.log 2>&1 \
   && ./obj_dir/tb_core_ctrl >> sim.log 2>&1 \
   || { cat sim.log; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- bench/tb_core_ctrl.sv
/*
 * Testbench for the core control block. Applies a table of host
 * commands over the req/ack port, checks settings, readback words,
 * handshake timing and load strobes, and after each command checks
 * the PPS select and the RX loopback path.
 */
`include "core_consts.svh"

module tb_core_ctrl;
   timeunit 1ns;
   timeprecision 1ps;

   // One host command and what it should leave behind
   typedef struct packed {
      core_pkg::cmd_op_t       op;
      core_pkg::setting_addr_t addr;
      core_pkg::set_word_t     data;
      core_pkg::rb_word_t      exp_rb;
      core_pkg::set_word_t     exp_out;
      logic                    chk_out;
      logic                    exp_ld_data;
      logic                    exp_ld_clk;
      logic                    exp_lb;
      logic                    exp_pps_sel;
      logic [1:0]              hold;
   } cmd_entry_t;

   logic                     radio_clk = 1'b0;
   logic                     i_reset;
   logic                     i_cmd_req;
   core_pkg::cmd_op_t        i_cmd_op;
   core_pkg::setting_addr_t  i_cmd_addr;
   core_pkg::set_word_t      i_cmd_data;
   logic                     o_cmd_ack;
   core_pkg::rb_word_t       o_rb_data;
   core_pkg::set_word_t      i_rb_misc;
   logic                     i_bist_done;
   logic                     i_bist_error;
   logic                     i_pps_int;
   logic                     i_pps_ext;
   logic                     o_pps;
   core_pkg::sample_t        i_rx0;
   core_pkg::sample_t        i_rx1;
   core_pkg::sample_t        i_tx0;
   core_pkg::sample_t        i_tx1;
   core_pkg::sample_t        o_rx0;
   core_pkg::sample_t        o_rx1;
   core_pkg::set_word_t      o_misc_outs;
   logic [`DELAY_W-1:0]      o_data_delay;
   logic [`DELAY_W-1:0]      o_clk_delay;
   logic                     o_ld_data_delay;
   logic                     o_ld_clk_delay;
   logic [2:0]               o_radio_control;
   logic [7:0]               o_gpsdo_st;

   int                       errors = 0;
   logic                     hung = 1'b0;
   logic [31:0]              lfsr_state = 32'h44ff0fe5;
   cmd_entry_t               cmd_table[$];
   logic                     model_lb = 1'b0;
   logic                     model_pps = 1'b0;
   logic                     pps_prev = 1'b0;
   core_pkg::rb_word_t       last_rb = '0;

   core_ctrl_top dut (.*);

   // 40 ns radio clock
   always #20 radio_clk = ~radio_clk;

   //------------------------------------------------------------
   // Stimulus source and compare tasks
   //------------------------------------------------------------
   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      int          k;
      val = '0;
      for (k = 0; k < n; k++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic check_rb(input string name, input core_pkg::rb_word_t got,
                           input core_pkg::rb_word_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input core_pkg::set_word_t got,
                             input core_pkg::set_word_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_sample(input string name, input core_pkg::sample_t got,
                               input core_pkg::sample_t exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // Picks the DUT output that a setting address drives
   function automatic core_pkg::set_word_t setting_out(input core_pkg::setting_addr_t a,
                                                       output string name);
      case (a)
         core_pkg::SET_DATA_DELAY: begin
            name = "o_data_delay";
            return core_pkg::set_word_t'(o_data_delay);
         end
         core_pkg::SET_CLK_DELAY: begin
            name = "o_clk_delay";
            return core_pkg::set_word_t'(o_clk_delay);
         end
         core_pkg::SET_RADIO_CONTROL: begin
            name = "o_radio_control";
            return core_pkg::set_word_t'(o_radio_control);
         end
         core_pkg::SET_GPSDO_ST: begin
            name = "o_gpsdo_st";
            return core_pkg::set_word_t'(o_gpsdo_st);
         end
         default: begin
            name = "o_misc_outs";
            return o_misc_outs;
         end
      endcase
   endfunction

   // Table row, expected outputs follow the register widths
   function automatic void add_cmd(input core_pkg::cmd_op_t op,
                                   input core_pkg::setting_addr_t addr,
                                   input core_pkg::set_word_t data,
                                   input core_pkg::rb_word_t exp_rb, input logic [1:0] hold);
      cmd_entry_t e;
      e        = '0;
      e.op     = op;
      e.addr   = addr;
      e.data   = data;
      e.exp_rb = exp_rb;
      e.hold   = hold;
      if (op == core_pkg::OP_WRITE) begin
         e.chk_out = 1'b1;
         case (addr)
            core_pkg::SET_MISC:          e.exp_out = data;
            core_pkg::SET_RADIO_CONTROL: e.exp_out = {29'h0, data[2:0]};
            core_pkg::SET_GPSDO_ST:      e.exp_out = {24'h0, data[7:0]};
            // 5-bit delays with a load pulse each
            core_pkg::SET_DATA_DELAY: begin
               e.exp_out     = {27'h0, data[4:0]};
               e.exp_ld_data = 1'b1;
            end
            core_pkg::SET_CLK_DELAY: begin
               e.exp_out    = {27'h0, data[4:0]};
               e.exp_ld_clk = 1'b1;
            end
            core_pkg::SET_LOOPBACK: begin
               e.chk_out = 1'b0;
               model_lb  = data[0];
            end
            core_pkg::SET_PPS_SEL: begin
               e.chk_out = 1'b0;
               model_pps = data[0];
            end
            default: e.chk_out = 1'b0;
         endcase
      end
      e.exp_lb      = model_lb;
      e.exp_pps_sel = model_pps;
      cmd_table.push_back(e);
   endfunction

   //------------------------------------------------------------
   // Handshake and radio side checks
   //------------------------------------------------------------
   // Lat counts from the cycle in which req is first seen
   task automatic wait_ack(input logic level, output int lat, inout int ld_d, inout int ld_c);
      int n;
      n   = 0;
      lat = -1;
      while (lat < 0 && n < 20) begin
         @(negedge radio_clk);
         ld_d += int'(o_ld_data_delay);
         ld_c += int'(o_ld_clk_delay);
         if (o_cmd_ack === level) begin
            lat = n;
         end
         n++;
      end
      if (lat < 0) begin
         hung = 1'b1;
         errors++;
         $display("Timeout: ack did not go to %0d within %0d cycles", level, n);
      end
   endtask

   task automatic run_cmd(input cmd_entry_t e);
      int    lat;
      int    ld_d;
      int    ld_c;
      string name;
      core_pkg::set_word_t got;
      ld_d = 0;
      ld_c = 0;
      @(posedge radio_clk);
      i_cmd_req  <= 1'b1;
      i_cmd_op   <= e.op;
      i_cmd_addr <= e.addr;
      i_cmd_data <= e.data;
      wait_ack(1'b1, lat, ld_d, ld_c);
      if (hung) return;
      if (lat != 3) begin
         errors++;
         $display("Ack rose %0d cycles after req instead of 3", lat);
      end
      // Readback only moves on reads
      if (e.op == core_pkg::OP_READ) begin
         last_rb = e.exp_rb;
      end
      check_rb("o_rb_data", o_rb_data, last_rb);
      if (e.chk_out) begin
         got = setting_out(e.addr, name);
         check_word(name, got, e.exp_out);
      end
      // Host stalls before dropping req
      repeat (e.hold) begin
         @(negedge radio_clk);
         check_flag("o_cmd_ack", o_cmd_ack, 1'b1);
      end
      @(posedge radio_clk);
      i_cmd_req <= 1'b0;
      wait_ack(1'b0, lat, ld_d, ld_c);
      if (hung) return;
      if (lat != 1) begin
         errors++;
         $display("Ack fell %0d cycles after req dropped instead of 1", lat);
      end
      if (ld_d != int'(e.exp_ld_data) || ld_c != int'(e.exp_ld_clk)) begin
         errors++;
         $display("Load strobes high for %0d and %0d cycles, expected %0d and %0d",
                  ld_d, ld_c, e.exp_ld_data, e.exp_ld_clk);
      end
   endtask

   // RX path one cycle behind, PPS two cycles behind
   task automatic check_radio(input logic lb, input logic sel);
      core_pkg::sample_t rx0;
      core_pkg::sample_t rx1;
      core_pkg::sample_t tx0;
      core_pkg::sample_t tx1;
      logic              old_pps;
      rx0     = lfsr_bits(32);
      rx1     = lfsr_bits(32);
      tx0     = lfsr_bits(32);
      tx1     = lfsr_bits(32);
      old_pps = sel ? ~pps_prev : pps_prev;
      pps_prev = ~pps_prev;
      @(posedge radio_clk);
      i_rx0     <= rx0;
      i_rx1     <= rx1;
      i_tx0     <= tx0;
      i_tx1     <= tx1;
      i_pps_int <= pps_prev;
      i_pps_ext <= ~pps_prev;
      repeat (2) @(negedge radio_clk);
      check_sample("o_rx0", o_rx0, lb ? tx0 : rx0);
      check_sample("o_rx1", o_rx1, lb ? tx1 : rx1);
      check_flag("o_pps", o_pps, old_pps);
      @(negedge radio_clk);
      check_flag("o_pps", o_pps, sel ? ~pps_prev : pps_prev);
   endtask

   //------------------------------------------------------------
   // Main sequence
   //------------------------------------------------------------
   initial begin
      core_pkg::set_word_t rb_misc_val;
      core_pkg::set_word_t gps_val;
      int                  i;
      rb_misc_val  = lfsr_bits(32);
      i_reset      <= 1'b1;
      i_cmd_req    <= 1'b0;
      i_cmd_op     <= core_pkg::OP_WRITE;
      i_cmd_addr   <= core_pkg::SET_LOOPBACK;
      i_cmd_data   <= '0;
      i_rb_misc    <= rb_misc_val;
      i_bist_done  <= 1'b1;
      i_bist_error <= 1'b0;
      i_pps_int    <= 1'b0;
      i_pps_ext    <= 1'b1;
      i_rx0        <= '0;
      i_rx1        <= '0;
      i_tx0        <= '0;
      i_tx1        <= '0;

      // Signature first, then status, delays, BIST, hash, loopback and PPS
      add_cmd(core_pkg::OP_READ, core_pkg::SET_LOOPBACK, '0,
              {`SIGNATURE_MAGIC, `PRODUCT_ID, `COMPAT_MAJOR, `COMPAT_MINOR}, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_MISC, lfsr_bits(32), '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_RADIO_CONTROL, lfsr_bits(32), '0, 2'd2);
      gps_val = lfsr_bits(32);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_GPSDO_ST, gps_val, '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_READBACK, 32'(`RB_STATUS), '0, 2'd0);
      add_cmd(core_pkg::OP_READ, core_pkg::SET_MISC, '0,
              {16'h0, 8'h00, gps_val[7:0], rb_misc_val}, 2'd3);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_DATA_DELAY, lfsr_bits(32), '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_CLK_DELAY, lfsr_bits(32), '0, 2'd1);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_READBACK, 32'(`RB_BIST), '0, 2'd0);
      add_cmd(core_pkg::OP_READ, core_pkg::SET_MISC, '0, {62'h0, 1'b0, 1'b1}, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_READBACK, 32'(`RB_GIT_HASH), '0, 2'd0);
      add_cmd(core_pkg::OP_READ, core_pkg::SET_MISC, '0, {32'h0, `GIT_HASH}, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_READBACK, 32'd1, '0, 2'd0);
      add_cmd(core_pkg::OP_READ, core_pkg::SET_MISC, '0, '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_LOOPBACK, lfsr_bits(32) | 32'd1, '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_PPS_SEL, lfsr_bits(32) | 32'd1, '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_LOOPBACK, lfsr_bits(32) & ~32'd1, '0, 2'd0);
      add_cmd(core_pkg::OP_WRITE, core_pkg::SET_PPS_SEL, lfsr_bits(32) & ~32'd1, '0, 2'd0);

      repeat (3) @(posedge radio_clk);
      i_reset <= 1'b0;
      @(negedge radio_clk);

      // Reset values
      check_flag("o_cmd_ack", o_cmd_ack, 1'b0);
      check_flag("o_ld_data_delay", o_ld_data_delay, 1'b0);
      check_flag("o_ld_clk_delay", o_ld_clk_delay, 1'b0);
      check_word("o_clk_delay", 32'(o_clk_delay), 32'(`CLK_DELAY_RESET));
      check_word("o_data_delay", 32'(o_data_delay), '0);
      check_word("o_misc_outs", o_misc_outs, '0);
      check_word("o_radio_control", 32'(o_radio_control), '0);

      for (i = 0; i < cmd_table.size() && !hung; i++) begin
         run_cmd(cmd_table[i]);
         if (!hung) begin
            check_radio(cmd_table[i].exp_lb, cmd_table[i].exp_pps_sel);
         end
      end

      $display("Checks done with %0d errors", errors);
      if (errors == 0 && !hung) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- design/core_ctrl_top.sv
/*
 * Top level of the core control block. Connects the command
 * decode, setting bank, readback mux and radio IO path on the
 * single radio clock.
 */
`include "core_consts.svh"

module core_ctrl_top (
   input  logic                      radio_clk,
   input  logic                      i_reset,
   // Host command port
   input  logic                      i_cmd_req,
   input  core_pkg::cmd_op_t         i_cmd_op,
   input  core_pkg::setting_addr_t   i_cmd_addr,
   input  core_pkg::set_word_t       i_cmd_data,
   output logic                      o_cmd_ack,
   output core_pkg::rb_word_t        o_rb_data,
   // Status inputs
   input  core_pkg::set_word_t       i_rb_misc,
   input  logic                      i_bist_done,
   input  logic                      i_bist_error,
   // Radio and PPS
   input  logic                      i_pps_int,
   input  logic                      i_pps_ext,
   output logic                      o_pps,
   input  core_pkg::sample_t         i_rx0,
   input  core_pkg::sample_t         i_rx1,
   input  core_pkg::sample_t         i_tx0,
   input  core_pkg::sample_t         i_tx1,
   output core_pkg::sample_t         o_rx0,
   output core_pkg::sample_t         o_rx1,
   // Setting outputs
   output core_pkg::set_word_t       o_misc_outs,
   output logic [`DELAY_W-1:0]       o_data_delay,
   output logic [`DELAY_W-1:0]       o_clk_delay,
   output logic                      o_ld_data_delay,
   output logic                      o_ld_clk_delay,
   output logic [2:0]                o_radio_control,
   output logic [7:0]                o_gpsdo_st
);

   logic                      wr_stb;
   core_pkg::setting_addr_t   wr_addr;
   core_pkg::set_word_t       wr_data;
   logic                      res_stb;
   logic                      is_read;
   logic                      loopback;
   logic                      pps_sel;
   core_pkg::rb_sel_t         rb_sel;

   cmd_decode u_cmd_decode (
      .radio_clk(radio_clk), .i_reset(i_reset),
      .i_cmd_req(i_cmd_req), .i_cmd_op(i_cmd_op),
      .i_cmd_addr(i_cmd_addr), .i_cmd_data(i_cmd_data), .i_ack(o_cmd_ack),
      .o_wr_stb(wr_stb), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
      .o_res_stb(res_stb), .o_is_read(is_read)
   );

   setting_bank u_setting_bank (
      .radio_clk(radio_clk), .i_reset(i_reset),
      .i_wr_stb(wr_stb), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
      .o_loopback(loopback), .o_misc_outs(o_misc_outs),
      .o_data_delay(o_data_delay), .o_clk_delay(o_clk_delay),
      .o_ld_data_delay(o_ld_data_delay), .o_ld_clk_delay(o_ld_clk_delay),
      .o_radio_control(o_radio_control), .o_rb_sel(rb_sel),
      .o_gpsdo_st(o_gpsdo_st), .o_pps_sel(pps_sel)
   );

   readback_mux u_readback_mux (
      .radio_clk(radio_clk), .i_reset(i_reset),
      .i_res_stb(res_stb), .i_is_read(is_read), .i_rb_sel(rb_sel),
      .i_gpsdo_st(o_gpsdo_st), .i_rb_misc(i_rb_misc),
      .i_bist_done(i_bist_done), .i_bist_error(i_bist_error),
      .i_cmd_req(i_cmd_req), .o_rb_data(o_rb_data), .o_cmd_ack(o_cmd_ack)
   );

   radio_io_path u_radio_io_path (
      .radio_clk(radio_clk), .i_reset(i_reset),
      .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext), .i_pps_sel(pps_sel),
      .i_loopback(loopback),
      .i_rx0(i_rx0), .i_rx1(i_rx1), .i_tx0(i_tx0), .i_tx1(i_tx1),
      .o_pps(o_pps), .o_rx0(o_rx0), .o_rx1(o_rx1)
   );

endmodule

//--- design/radio_io_path.sv
/*
 * Radio side helpers. Two-flop synchronizers on both PPS inputs
 * with a select between them, and the registered RX path with
 * TX-to-RX loopback for both channels.
 */
module radio_io_path (
   input  logic         radio_clk,
   input  logic         i_reset,
   input  logic         i_pps_int,
   input  logic         i_pps_ext,
   input  logic         i_pps_sel,
   input  logic         i_loopback,
   input  logic [31:0]  i_rx0,
   input  logic [31:0]  i_rx1,
   input  logic [31:0]  i_tx0,
   input  logic [31:0]  i_tx1,
   output logic         o_pps,
   output logic [31:0]  o_rx0,
   output logic [31:0]  o_rx1
);

   logic [1:0] pps_int_sync;
   logic [1:0] pps_ext_sync;

   //------------------------------------------------------------
   // PPS synchronizers
   //------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         pps_int_sync <= 2'b00;
         pps_ext_sync <= 2'b00;
      end else begin
         pps_int_sync <= {pps_int_sync[0], i_pps_int};
         pps_ext_sync <= {pps_ext_sync[0], i_pps_ext};
      end
   end

   // 1 selects external
   assign o_pps = i_pps_sel ? pps_ext_sync[1] : pps_int_sync[1];

   // RX capture, loopback swaps in the TX sample
   always_ff @(posedge radio_clk) begin
      o_rx0 <= i_loopback ? i_tx0 : i_rx0;
      o_rx1 <= i_loopback ? i_tx1 : i_rx1;
   end

endmodule

//--- design/readback_mux.sv
/*
 * Result stage. Builds the 64-bit readback word from the current
 * select, registers it on a read result and drives the command
 * acknowledge until the host drops req.
 */
`include "core_consts.svh"

module readback_mux (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  logic                  i_res_stb,
   input  logic                  i_is_read,
   input  core_pkg::rb_sel_t     i_rb_sel,
   input  logic [7:0]            i_gpsdo_st,
   input  core_pkg::set_word_t   i_rb_misc,
   input  logic                  i_bist_done,
   input  logic                  i_bist_error,
   input  logic                  i_cmd_req,
   output core_pkg::rb_word_t    o_rb_data,
   output logic                  o_cmd_ack
);

   core_pkg::rb_word_t rb_word;

   // Readback word select, radio status byte reads zero
   always_comb begin
      case (i_rb_sel)
         core_pkg::RB_SEL_SIGNATURE:
            rb_word = {`SIGNATURE_MAGIC, `PRODUCT_ID, `COMPAT_MAJOR, `COMPAT_MINOR};
         core_pkg::RB_SEL_STATUS:
            rb_word = {16'h0, 8'h00, i_gpsdo_st, i_rb_misc};
         core_pkg::RB_SEL_BIST:
            rb_word = {62'h0, i_bist_error, i_bist_done};
         core_pkg::RB_SEL_GIT_HASH:
            rb_word = {32'h0, `GIT_HASH};
         default:
            rb_word = '0;
      endcase
   end

   // Word only updates on reads, writes leave it alone
   always_ff @(posedge radio_clk) begin
      if (i_res_stb && i_is_read) begin
         o_rb_data <= rb_word;
      end
   end

   // Ack set by result, cleared once req is low
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_cmd_ack <= 1'b0;
      end else if (i_res_stb) begin
         o_cmd_ack <= 1'b1;
      end else if (!i_cmd_req) begin
         o_cmd_ack <= 1'b0;
      end
   end

   // Ack only answers a request still being held
   ack_needs_req : assert property (@(posedge radio_clk) disable iff (i_reset)
      $rose(o_cmd_ack) |-> $past(i_cmd_req));

endmodule

//--- design/setting_bank.sv
/*
 * Execute stage. Eight setting registers loaded from the decoded
 * write strobe, each keeping only the low bits it needs. Writes to
 * the delay registers also raise a one-cycle load strobe.
 */
`include "core_consts.svh"

module setting_bank (
   input  logic                      radio_clk,
   input  logic                      i_reset,
   input  logic                      i_wr_stb,
   input  core_pkg::setting_addr_t   i_wr_addr,
   input  core_pkg::set_word_t       i_wr_data,
   output logic                      o_loopback,
   output core_pkg::set_word_t       o_misc_outs,
   output logic [`DELAY_W-1:0]       o_data_delay,
   output logic [`DELAY_W-1:0]       o_clk_delay,
   output logic                      o_ld_data_delay,
   output logic                      o_ld_clk_delay,
   output logic [2:0]                o_radio_control,
   output core_pkg::rb_sel_t         o_rb_sel,
   output logic [7:0]                o_gpsdo_st,
   output logic                      o_pps_sel
);

   //------------------------------------------------------------
   // Resettable settings
   //------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_loopback      <= 1'b0;
         o_misc_outs     <= '0;
         o_data_delay    <= '0;
         o_clk_delay     <= `DELAY_W'(`CLK_DELAY_RESET);
         o_ld_data_delay <= 1'b0;
         o_ld_clk_delay  <= 1'b0;
         o_radio_control <= 3'd0;
         o_rb_sel        <= core_pkg::RB_SEL_SIGNATURE;
         o_pps_sel       <= 1'b0;
      end else begin
         o_ld_data_delay <= 1'b0;
         o_ld_clk_delay  <= 1'b0;
         if (i_wr_stb) begin
            case (i_wr_addr)
               core_pkg::SET_LOOPBACK:      o_loopback <= i_wr_data[0];
               core_pkg::SET_MISC:          o_misc_outs <= i_wr_data;
               // Delay writes pulse the matching load line
               core_pkg::SET_DATA_DELAY: begin
                  o_data_delay    <= i_wr_data[`DELAY_W-1:0];
                  o_ld_data_delay <= 1'b1;
               end
               core_pkg::SET_CLK_DELAY: begin
                  o_clk_delay    <= i_wr_data[`DELAY_W-1:0];
                  o_ld_clk_delay <= 1'b1;
               end
               core_pkg::SET_RADIO_CONTROL: o_radio_control <= i_wr_data[2:0];
               core_pkg::SET_READBACK:      o_rb_sel <= core_pkg::rb_sel_t'(i_wr_data[2:0]);
               core_pkg::SET_PPS_SEL:       o_pps_sel <= i_wr_data[0];
               default: ;
            endcase
         end
      end
   end

   // GPSDO status survives reset
   always_ff @(posedge radio_clk) begin
      if (i_wr_stb && i_wr_addr == core_pkg::SET_GPSDO_ST) begin
         o_gpsdo_st <= i_wr_data[7:0];
      end
   end

   // Load strobes never stretch past one cycle
   ld_data_one_cycle : assert property (@(posedge radio_clk) disable iff (i_reset)
      o_ld_data_delay |=> !o_ld_data_delay);

   ld_clk_one_cycle : assert property (@(posedge radio_clk) disable iff (i_reset)
      o_ld_clk_delay |=> !o_ld_clk_delay);

endmodule

//--- design/cmd_decode.sv
/*
 * Command decode stage. Runs the device side of the four-phase
 * req/ack handshake, captures one command per request and turns
 * it into a setting write strobe and a result strobe.
 */
module cmd_decode (
   input  logic                      radio_clk,
   input  logic                      i_reset,
   input  logic                      i_cmd_req,
   input  core_pkg::cmd_op_t         i_cmd_op,
   input  core_pkg::setting_addr_t   i_cmd_addr,
   input  core_pkg::set_word_t       i_cmd_data,
   input  logic                      i_ack,
   output logic                      o_wr_stb,
   output core_pkg::setting_addr_t   o_wr_addr,
   output core_pkg::set_word_t       o_wr_data,
   output logic                      o_res_stb,
   output logic                      o_is_read
);

   core_pkg::decode_state_t state;

   //------------------------------------------------------------
   // Handshake FSM
   //------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state     <= core_pkg::ST_IDLE;
         o_wr_stb  <= 1'b0;
         o_res_stb <= 1'b0;
      end else begin
         // Strobes are single cycle
         o_wr_stb  <= 1'b0;
         o_res_stb <= 1'b0;
         case (state)
            core_pkg::ST_IDLE: begin
               if (i_cmd_req) begin
                  state    <= core_pkg::ST_EXEC;
                  o_wr_stb <= (i_cmd_op == core_pkg::OP_WRITE);
               end
            end
            // Setting bank takes the write this cycle
            core_pkg::ST_EXEC: begin
               state     <= core_pkg::ST_RESULT;
               o_res_stb <= 1'b1;
            end
            // Readback mux registers ack this cycle
            core_pkg::ST_RESULT: state <= core_pkg::ST_HOLD;
            // Wait for host to release req
            core_pkg::ST_HOLD: begin
               if (i_ack && !i_cmd_req) begin
                  state <= core_pkg::ST_IDLE;
               end
            end
            default: state <= core_pkg::ST_IDLE;
         endcase
      end
   end

   // Command capture on the accepted request
   // Host holds the fields stable until ack
   always_ff @(posedge radio_clk) begin
      if (state == core_pkg::ST_IDLE && i_cmd_req) begin
         o_wr_addr <= i_cmd_addr;
         o_wr_data <= i_cmd_data;
         o_is_read <= (i_cmd_op == core_pkg::OP_READ);
      end
   end

   // Write strobe only in the execute stage
   wr_stb_in_exec : assert property (@(posedge radio_clk) disable iff (i_reset)
      o_wr_stb |-> (state == core_pkg::ST_EXEC));

endmodule

//--- design/core_pkg.sv
/*
 * Shared types for the core control block.
 * Opcode, setting address, readback select and decode state
 * enums, plus the data word types. Referenced by scoped name.
 */
`include "core_consts.svh"

package core_pkg;

   // Host command opcode
   typedef enum logic {
      OP_WRITE = 1'b0,
      OP_READ  = 1'b1
   } cmd_op_t;

   // Setting register map
   typedef enum logic [7:0] {
      SET_LOOPBACK      = `SR_LOOPBACK,
      SET_MISC          = `SR_MISC,
      SET_DATA_DELAY    = `SR_DATA_DELAY,
      SET_CLK_DELAY     = `SR_CLK_DELAY,
      SET_RADIO_CONTROL = `SR_RADIO_CONTROL,
      SET_READBACK      = `SR_READBACK,
      SET_GPSDO_ST      = `SR_GPSDO_ST,
      SET_PPS_SEL       = `SR_PPS_SEL
   } setting_addr_t;

   // Readback word selects
   typedef enum logic [2:0] {
      RB_SEL_SIGNATURE = `RB_SIGNATURE,
      RB_SEL_STATUS    = `RB_STATUS,
      RB_SEL_BIST      = `RB_BIST,
      RB_SEL_GIT_HASH  = `RB_GIT_HASH
   } rb_sel_t;

   // Command decode FSM
   typedef enum logic [1:0] {
      ST_IDLE, ST_EXEC, ST_RESULT, ST_HOLD
   } decode_state_t;

   typedef logic [31:0] set_word_t;
   typedef logic [63:0] rb_word_t;
   typedef logic [31:0] sample_t;

endpackage

//--- include/core_consts.svh
/*
 * Global control constants for the core control block.
 * Setting addresses, readback selects, reset values and
 * identification fields. Included by the package and by
 * any module or bench that needs a raw value.
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Setting register addresses
`define SR_LOOPBACK       8'd0
`define SR_MISC           8'd1
`define SR_DATA_DELAY     8'd2
`define SR_CLK_DELAY      8'd3
`define SR_RADIO_CONTROL  8'd4
`define SR_READBACK       8'd5
`define SR_GPSDO_ST       8'd6
`define SR_PPS_SEL        8'd7

// Readback selects, select 1 unused
`define RB_SIGNATURE      3'd0
`define RB_STATUS         3'd2
`define RB_BIST           3'd3
`define RB_GIT_HASH       3'd4

// Delay line control
`define DELAY_W           5
`define CLK_DELAY_RESET   16

// Identification fields
`define SIGNATURE_MAGIC   32'hACE0BA5E
`define PRODUCT_ID        16'h0230
`define COMPAT_MAJOR      8'h03
`define COMPAT_MINOR      8'h01
// Top nibble f marks an unclean build
`define GIT_HASH          32'hf7c0e93a

`endif
